// ==== audio_tone_cfg.svh ====
`ifndef AUDIO_TONE_CFG_SVH
`define AUDIO_TONE_CFG_SVH

// sample rate and sample path sizing
`define AT_TICK_DIV 8192 // clk_m cycles per sample tick, ~12 kHz at 98.3 MHz
`define AT_FIFO_DEPTH 8 // sample fifo entries
`define AT_SAMPLE_W 8 // mixed sample width
`define AT_PHASE_W 32 // dds phase accumulator width
`define AT_LEVEL_W 4 // fifo level width, holds 0..depth

// axi4-lite register port
`define AT_ADDR_W 4
`define AT_DATA_W 32

`define AT_ADDR_INCR0 4'h0 // voice 0 phase increment
`define AT_ADDR_INCR1 4'h4 // voice 1 phase increment
`define AT_ADDR_CTRL 4'h8 // voice_en[1:0] spk_en[3:2] play_en[4], bit 31 clears overflow
`define AT_ADDR_STATUS 4'hC // overflow[0] level[11:8] last_sample[23:16]

`endif

// ==== audio_tone_pkg.sv ====
package audio_tone_pkg;

`include "audio_tone_cfg.svh"

  typedef struct packed {
    logic [`AT_PHASE_W-1:0] incr0; // voice 0 phase step
    logic [`AT_PHASE_W-1:0] incr1; // voice 1 phase step
    logic [1:0] voice_en; // per voice mix enable
    logic [1:0] spk_en; // bit 0 left, bit 1 right
    logic play_en; // player pulls samples
  } at_ctrl_t;

  typedef struct packed {
    logic valid; // one cycle strobe
    logic [`AT_SAMPLE_W-1:0] data; // offset binary sample
  } at_sample_t;

  typedef struct packed {
    logic overflow; // sticky, fifo dropped a sample
    logic [`AT_LEVEL_W-1:0] fifo_level;
    logic [`AT_SAMPLE_W-1:0] last_sample; // last sample taken by player
  } at_status_t;

  typedef enum logic {
    WR_IDLE, // waiting for aw and w together
    WR_RESP // bvalid held until bready
  } axil_wr_state_e;

  typedef enum logic {
    RD_IDLE, // waiting for ar
    RD_DATA // rvalid held until rready
  } axil_rd_state_e;

  typedef enum logic [1:0] {
    AXIL_OKAY = 2'b00,
    AXIL_SLVERR = 2'b10
  } axil_resp_e;

endpackage

// ==== audio_tone_regs.sv ====
`include "audio_tone_cfg.svh"

module audio_tone_regs import audio_tone_pkg::*; (
  input logic clk_m,
  input logic arst_n,
  input logic [`AT_ADDR_W-1:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [`AT_DATA_W-1:0] wdata,
  input logic [`AT_DATA_W/8-1:0] wstrb,
  input logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input logic bready,
  input logic [`AT_ADDR_W-1:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic [`AT_DATA_W-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready,
  output at_ctrl_t ctrl,
  output logic clr_ovf,
  input at_status_t status
);

  axil_wr_state_e wr_state;
  axil_rd_state_e rd_state;
  at_ctrl_t ctrl_q;
  logic wr_go; // aw and w taken this cycle
  logic wr_err;
  logic rd_err;
  logic [`AT_DATA_W-1:0] rd_word;

  // byte lane merge for the wide registers
  function automatic logic [`AT_DATA_W-1:0] merge_strb(input logic [`AT_DATA_W-1:0] old_v,
                                                       input logic [`AT_DATA_W-1:0] new_v,
                                                       input logic [`AT_DATA_W/8-1:0] strb);
    logic [`AT_DATA_W-1:0] res;
    for (int b = 0; b < `AT_DATA_W/8; b++) begin
      res[8*b +: 8] = strb[b] ? new_v[8*b +: 8] : old_v[8*b +: 8];
    end
    return res;
  endfunction

  assign wr_go = (wr_state == WR_IDLE) && awvalid && wvalid; // both channels at once
  assign awready = wr_go;
  assign wready = wr_go;
  assign bvalid = (wr_state == WR_RESP);
  assign arready = (rd_state == RD_IDLE) && arvalid; // low while rvalid pending
  assign rvalid = (rd_state == RD_DATA);
  assign ctrl = ctrl_q;

  always_comb begin
    case (awaddr)
      `AT_ADDR_INCR0, `AT_ADDR_INCR1, `AT_ADDR_CTRL: wr_err = 1'b0;
      default: wr_err = 1'b1; // status is read only
    endcase
  end

  always_comb begin
    rd_word = '0;
    rd_err = 1'b0;
    case (araddr)
      `AT_ADDR_INCR0: rd_word = ctrl_q.incr0;
      `AT_ADDR_INCR1: rd_word = ctrl_q.incr1;
      `AT_ADDR_CTRL: rd_word[4:0] = {ctrl_q.play_en, ctrl_q.spk_en, ctrl_q.voice_en};
      `AT_ADDR_STATUS: begin
        rd_word[0] = status.overflow;
        rd_word[8 +: `AT_LEVEL_W] = status.fifo_level;
        rd_word[16 +: `AT_SAMPLE_W] = status.last_sample;
      end
      default: rd_err = 1'b1; // unmapped
    endcase
  end

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      wr_state <= WR_IDLE;
      bresp <= AXIL_OKAY;
      ctrl_q <= '0;
      clr_ovf <= 1'b0;
    end else begin
      clr_ovf <= 1'b0; // single cycle pulse
      case (wr_state)
        WR_IDLE: begin
          if (wr_go) begin
            wr_state <= WR_RESP;
            bresp <= wr_err ? AXIL_SLVERR : AXIL_OKAY;
            case (awaddr)
              `AT_ADDR_INCR0: ctrl_q.incr0 <= merge_strb(ctrl_q.incr0, wdata, wstrb);
              `AT_ADDR_INCR1: ctrl_q.incr1 <= merge_strb(ctrl_q.incr1, wdata, wstrb);
              `AT_ADDR_CTRL: begin
                if (wstrb[0]) begin
                  ctrl_q.voice_en <= wdata[1:0];
                  ctrl_q.spk_en <= wdata[3:2];
                  ctrl_q.play_en <= wdata[4];
                end
                clr_ovf <= wstrb[3] & wdata[31]; // overflow clear request
              end
              default: ; // slverr, nothing changes
            endcase
          end
        end
        WR_RESP: if (bready) wr_state <= WR_IDLE;
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      rd_state <= RD_IDLE;
      rdata <= '0;
      rresp <= AXIL_OKAY;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (arready) begin
            rd_state <= RD_DATA;
            rdata <= rd_word; // captured at ar transfer
            rresp <= rd_err ? AXIL_SLVERR : AXIL_OKAY;
          end
        end
        RD_DATA: if (rready) rd_state <= RD_IDLE;
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // a response once offered must wait for its handshake
  a_bvalid_hold: assert property (@(posedge clk_m) disable iff (!arst_n)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk_m) disable iff (!arst_n)
    rvalid && !rready |=> rvalid);

endmodule

// ==== sine_generator.sv ====
module sine_generator #(
  parameter int PHASE_W = 32
) (
  input logic clk_m,
  input logic arst_n,
  input logic step, // advance one sample
  input logic [PHASE_W-1:0] incr,
  output logic [7:0] amp // offset binary around 128
);

  // first quadrant of sin scaled to 127
  localparam logic [6:0] QTAB [64] = '{
      0,   3,   6,   9,  12,  16,  19,  22,
     25,  28,  31,  34,  37,  40,  43,  46,
     49,  51,  54,  57,  60,  63,  65,  68,
     71,  73,  76,  78,  81,  83,  85,  88,
     90,  92,  94,  96,  98, 100, 102, 104,
    106, 107, 109, 111, 112, 113, 115, 116,
    117, 118, 120, 121, 122, 122, 123, 124,
    125, 125, 126, 126, 126, 127, 127, 127
  };

  logic [PHASE_W-1:0] phase;
  logic [1:0] quad; // top two phase bits
  logic [5:0] idx;
  logic [6:0] mag;
  logic [7:0] amp_next;

  assign quad = phase[PHASE_W-1 -: 2];
  assign idx = quad[0] ? ~phase[PHASE_W-3 -: 6] : phase[PHASE_W-3 -: 6]; // mirror falling half
  assign mag = QTAB[idx];
  assign amp_next = quad[1] ? 8'd128 - {1'b0, mag} : 8'd128 + {1'b0, mag}; // negative half

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      phase <= '0;
      amp <= 8'd128; // midscale at phase 0
    end else if (step) begin
      phase <= phase + incr; // wraps naturally
      amp <= amp_next; // sample of current phase
    end
  end

endmodule

// ==== tone_source.sv ====
`include "audio_tone_cfg.svh"

module tone_source import audio_tone_pkg::*; (
  input logic clk_m,
  input logic arst_n,
  input at_ctrl_t ctrl,
  output logic tick, // one cycle per sample period
  output at_sample_t sample
);

  localparam int CNT_W = $clog2(`AT_TICK_DIV);

  logic [CNT_W-1:0] tick_cnt;
  logic tick_d; // voices settled
  logic [`AT_SAMPLE_W-1:0] amp0;
  logic [`AT_SAMPLE_W-1:0] amp1;
  logic [`AT_SAMPLE_W:0] mix_sum; // one extra bit for the carry

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
      tick <= 1'b0;
    end else if (tick_cnt == CNT_W'(`AT_TICK_DIV - 1)) begin
      tick_cnt <= '0;
      tick <= 1'b1; // first one div cycles after reset
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
      tick <= 1'b0;
    end
  end

  sine_generator #(
    .PHASE_W(`AT_PHASE_W)
  ) u_voice0 (
    .clk_m (clk_m),
    .arst_n(arst_n),
    .step  (tick),
    .incr  (ctrl.incr0),
    .amp   (amp0)
  );

  sine_generator #(
    .PHASE_W(`AT_PHASE_W)
  ) u_voice1 (
    .clk_m (clk_m),
    .arst_n(arst_n),
    .step  (tick),
    .incr  (ctrl.incr1),
    .amp   (amp1)
  );

  // disabled voice counts as zero, halve the sum
  assign mix_sum = {1'b0, ctrl.voice_en[0] ? amp0 : '0} + {1'b0, ctrl.voice_en[1] ? amp1 : '0};

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      tick_d <= 1'b0;
      sample <= '0;
    end else begin
      tick_d <= tick;
      sample.valid <= tick_d; // two cycles after tick
      if (tick_d) sample.data <= mix_sum[`AT_SAMPLE_W:1];
    end
  end

  a_tick_single: assert property (@(posedge clk_m) disable iff (!arst_n) tick |=> !tick);

endmodule

// ==== sample_fifo.sv ====
module sample_fifo import audio_tone_pkg::*; #(
  parameter int DEPTH = 8
) (
  input logic clk_m,
  input logic arst_n,
  input at_sample_t wr_sample, // pushed on valid
  input logic rd_en,
  output at_sample_t rd_sample, // head entry, valid when not empty
  output logic empty,
  output logic [$clog2(DEPTH+1)-1:0] level,
  output logic overflow,
  input logic clr_ovf
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int LVL_W = $clog2(DEPTH + 1);

  at_sample_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic full;
  logic push;
  logic pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1; // wraps for any depth
  endfunction

  assign full = (level == LVL_W'(DEPTH));
  assign empty = (level == '0);
  assign push = wr_sample.valid & ~full; // full drops the sample
  assign pop = rd_en & ~empty;
  assign rd_sample.valid = ~empty;
  assign rd_sample.data = mem[rd_ptr].data; // show ahead

  always_ff @(posedge clk_m) begin
    if (push) mem[wr_ptr] <= wr_sample;
  end

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, pop})
        2'b10: level <= level + 1'b1;
        2'b01: level <= level - 1'b1;
        default: ; // both or neither
      endcase
      if (wr_sample.valid && full) overflow <= 1'b1; // a new drop beats the clear
      else if (clr_ovf) overflow <= 1'b0;
    end
  end

  a_level_bound: assert property (@(posedge clk_m) disable iff (!arst_n)
    level <= LVL_W'(DEPTH));

endmodule

// ==== audio_player.sv ====
`include "audio_tone_cfg.svh"

module audio_player import audio_tone_pkg::*; (
  input logic clk_m,
  input logic arst_n,
  input at_ctrl_t ctrl,
  input logic tick,
  input at_sample_t rd_sample,
  input logic empty,
  output logic rd_en,
  output logic [`AT_SAMPLE_W-1:0] last_sample, // held modulator sample
  output logic spkl,
  output logic spkr
);

  logic [`AT_SAMPLE_W-1:0] mod_in;
  logic [`AT_SAMPLE_W:0] acc; // msb is the output bit

  assign rd_en = tick & ctrl.play_en & ~empty; // one pop per tick
  assign mod_in = ctrl.play_en ? last_sample : '0; // silence when stopped

  always_ff @(posedge clk_m or negedge arst_n) begin
    if (!arst_n) begin
      last_sample <= '0;
      acc <= '0;
    end else begin
      if (rd_en) last_sample <= rd_sample.data; // used from next cycle
      acc <= {1'b0, acc[`AT_SAMPLE_W-1:0]} + {1'b0, mod_in}; // carry out each cycle
    end
  end

  // ones density over 256 cycles tracks the sample
  assign spkl = ctrl.spk_en[0] & acc[`AT_SAMPLE_W];
  assign spkr = ctrl.spk_en[1] & acc[`AT_SAMPLE_W];

endmodule

// ==== audio_tone_top.sv ====
`include "audio_tone_cfg.svh"

module audio_tone_top import audio_tone_pkg::*; (
  input logic clk_m,
  input logic arst_n,
  input logic [`AT_ADDR_W-1:0] awaddr,
  input logic awvalid,
  output logic awready,
  input logic [`AT_DATA_W-1:0] wdata,
  input logic [`AT_DATA_W/8-1:0] wstrb,
  input logic wvalid,
  output logic wready,
  output logic [1:0] bresp,
  output logic bvalid,
  input logic bready,
  input logic [`AT_ADDR_W-1:0] araddr,
  input logic arvalid,
  output logic arready,
  output logic [`AT_DATA_W-1:0] rdata,
  output logic [1:0] rresp,
  output logic rvalid,
  input logic rready,
  output logic spkl, // left speaker bit stream
  output logic spkr // right speaker bit stream
);

  at_ctrl_t ctrl;
  at_status_t status;
  at_sample_t sample; // mixer to fifo
  at_sample_t rd_sample; // fifo head to player
  logic clr_ovf;
  logic tick; // shared by source and player
  logic rd_en;
  logic empty;
  logic overflow;
  logic [`AT_LEVEL_W-1:0] fifo_level;
  logic [`AT_SAMPLE_W-1:0] last_sample;

  assign status.overflow = overflow;
  assign status.fifo_level = fifo_level;
  assign status.last_sample = last_sample;

  audio_tone_regs u_regs (
    .clk_m  (clk_m),
    .arst_n (arst_n),
    .awaddr (awaddr),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wvalid (wvalid),
    .wready (wready),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .araddr (araddr),
    .arvalid(arvalid),
    .arready(arready),
    .rdata  (rdata),
    .rresp  (rresp),
    .rvalid (rvalid),
    .rready (rready),
    .ctrl   (ctrl),
    .clr_ovf(clr_ovf),
    .status (status)
  );

  tone_source u_source (
    .clk_m (clk_m),
    .arst_n(arst_n),
    .ctrl  (ctrl),
    .tick  (tick),
    .sample(sample)
  );

  sample_fifo #(
    .DEPTH(`AT_FIFO_DEPTH)
  ) u_fifo (
    .clk_m    (clk_m),
    .arst_n   (arst_n),
    .wr_sample(sample),
    .rd_en    (rd_en),
    .rd_sample(rd_sample),
    .empty    (empty),
    .level    (fifo_level),
    .overflow (overflow),
    .clr_ovf  (clr_ovf)
  );

  audio_player u_player (
    .clk_m      (clk_m),
    .arst_n     (arst_n),
    .ctrl       (ctrl),
    .tick       (tick),
    .rd_sample  (rd_sample),
    .empty      (empty),
    .rd_en      (rd_en),
    .last_sample(last_sample),
    .spkl       (spkl),
    .spkr       (spkr)
  );

endmodule

// ==== tb_audio_tone.sv ====
`include "audio_tone_cfg.svh"

module tb_audio_tone;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk_m;
  logic arst_n;
  logic [`AT_ADDR_W-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [`AT_DATA_W-1:0] wdata;
  logic [`AT_DATA_W/8-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [`AT_ADDR_W-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [`AT_DATA_W-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic spkl;
  logic spkr;
  logic [31:0] lfsr_state;
  logic play_may; // player might be running
  logic spk_both; // both speakers surely on

  audio_tone_top u_audio_tone_top (.*);

  initial clk_m = 1'b0;
  always #50 clk_m = ~clk_m; // 10 MHz

  task automatic stop_failed();
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("FAIL %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
    stop_failed();
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    stop_failed();
  endtask

  // galois form of x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      w[i] = lfsr_state[0];
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_m);
    #10; // drive and sample point
  endtask

  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int guard;
    awaddr = addr;
    wdata = data;
    wstrb = 4'hf;
    awvalid = 1'b1;
    wvalid = 1'b1;
    guard = 0;
    do begin
      @(negedge clk_m); // ready settled mid cycle
      guard++;
      if (guard > 16) abort_run("write address and data never accepted");
    end while (!(awready && wready));
    next_cycle(); // transfer on this edge
    awvalid = 1'b0;
    wvalid = 1'b0;
    guard = 0;
    while (!bvalid) begin
      next_cycle();
      guard++;
      if (guard > 16) abort_run("write response never arrived");
    end
    next_cycle(); // b held one cycle without bready
    bready = 1'b1;
    resp = bresp;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int guard;
    araddr = addr;
    arvalid = 1'b1;
    guard = 0;
    do begin
      @(negedge clk_m); // ready settled mid cycle
      guard++;
      if (guard > 16) abort_run("read address never accepted");
    end while (!arready);
    next_cycle();
    arvalid = 1'b0;
    guard = 0;
    while (!rvalid) begin
      next_cycle();
      guard++;
      if (guard > 16) abort_run("read data never arrived");
    end
    next_cycle(); // r held one cycle without rready
    rready = 1'b1;
    data = rdata;
    resp = rresp;
    next_cycle();
    rready = 1'b0;
  endtask

  // returns 2 cycles after a tick, far from the next one
  task automatic wait_samples(input int count);
    int seen;
    int guard;
    seen = 0;
    guard = 0;
    while (seen < count) begin
      next_cycle();
      guard++;
      if (u_audio_tone_top.sample.valid) begin
        seen++;
        guard = 0;
      end
      if (guard > 2 * `AT_TICK_DIV) abort_run("no sample pushed within two tick periods");
    end
  endtask

  task automatic write_ctrl(input string test, input logic [31:0] word);
    logic [1:0] resp;
    play_may = play_may | word[4]; // widen the guards before the change lands
    spk_both = spk_both & (word[3:2] == 2'b11);
    axil_write(`AT_ADDR_CTRL, word, resp);
    assert (resp == 2'b00) else report_mismatch(test, "ctrl bresp", 32'h0, 32'(resp));
    play_may = word[4];
    spk_both = (word[3:2] == 2'b11);
  endtask

  task automatic read_status(input string test, output logic ovf, output int lvl,
                             output int last);
    logic [31:0] word;
    logic [1:0] resp;
    axil_read(`AT_ADDR_STATUS, word, resp);
    assert (resp == 2'b00) else report_mismatch(test, "status rresp", 32'h0, 32'(resp));
    ovf = word[0];
    lvl = int'(word[11:8]);
    last = int'(word[23:16]);
  endtask

  // stale fifo entries play out first
  task automatic wait_last_sample(input string test, input int exp);
    logic ovf;
    int lvl;
    int last;
    int polls;
    polls = 0;
    read_status(test, ovf, lvl, last);
    while (last != exp) begin
      wait_samples(1);
      read_status(test, ovf, lvl, last);
      polls++;
      if (polls > `AT_FIFO_DEPTH + 4) report_mismatch(test, "last_sample", exp, last);
    end
  endtask

  task automatic count_ones(output int l_ones, output int r_ones);
    l_ones = 0;
    r_ones = 0;
    for (int i = 0; i < 256; i++) begin
      next_cycle();
      l_ones += int'(spkl);
      r_ones += int'(spkr);
    end
  endtask

  a_silent_when_stopped: assert property (@(posedge clk_m) disable iff (!arst_n)
    !play_may |-> !spkl && !spkr)
    else report_mismatch("silence", "spkl spkr", 32'h0, {30'h0, spkl, spkr});
  a_right_follows_left: assert property (@(posedge clk_m) disable iff (!arst_n)
    spk_both |-> spkr == spkl)
    else report_mismatch("speaker match", "spkr", 32'(spkl), 32'(spkr));

  initial begin
    logic [31:0] incr_a;
    logic [31:0] incr_b;
    logic [31:0] rd;
    logic [1:0] resp;
    logic ovf;
    int lvl;
    int last;
    int first_last;
    int l_ones;
    int r_ones;
    bit moved;
    lfsr_state = 32'hfeeb_65fd;
    arst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    play_may = 1'b0;
    spk_both = 1'b0;
    repeat (5) @(posedge clk_m);
    #10;
    arst_n = 1'b1;
    assert (!bvalid && !rvalid && !arready && !spkl && !spkr)
      else abort_run("handshake or speaker output active after reset");

    // register access, all before the first tick so both phases stay at 0
    random_word(incr_a);
    random_word(incr_b);
    axil_write(`AT_ADDR_INCR0, incr_a, resp);
    assert (resp == 2'b00) else report_mismatch("regs", "incr0 bresp", 32'h0, 32'(resp));
    axil_write(`AT_ADDR_INCR1, incr_b, resp);
    assert (resp == 2'b00) else report_mismatch("regs", "incr1 bresp", 32'h0, 32'(resp));
    axil_read(`AT_ADDR_INCR0, rd, resp);
    assert (resp == 2'b00 && rd == incr_a) else report_mismatch("regs", "incr0", incr_a, rd);
    axil_read(`AT_ADDR_INCR1, rd, resp);
    assert (resp == 2'b00 && rd == incr_b) else report_mismatch("regs", "incr1", incr_b, rd);
    axil_read(4'h2, rd, resp); // unmapped
    assert (resp == 2'b10) else report_mismatch("regs", "unmapped rresp", 32'h2, 32'(resp));
    axil_write(`AT_ADDR_STATUS, 32'hffff_ffff, resp);
    assert (resp == 2'b10) else report_mismatch("regs", "status bresp", 32'h2, 32'(resp));
    axil_read(`AT_ADDR_CTRL, rd, resp);
    assert (rd == 32'h0) else report_mismatch("regs", "ctrl after slverr", 32'h0, rd);
    axil_read(`AT_ADDR_INCR0, rd, resp);
    assert (rd == incr_a) else report_mismatch("regs", "incr0 after slverr", incr_a, rd);
    axil_write(`AT_ADDR_INCR0, 32'h0, resp);
    axil_write(`AT_ADDR_INCR1, 32'h0, resp);

    // silence with play off, fifo fills meanwhile
    wait_samples(3);
    count_ones(l_ones, r_ones);
    assert (l_ones == 0 && r_ones == 0)
      else report_mismatch("silence", "ones", 32'h0, 32'(l_ones + r_ones));

    // midscale: two voices at phase 0 average to 128
    write_ctrl("midscale", 32'h1f);
    wait_last_sample("midscale", 128);
    count_ones(l_ones, r_ones);
    assert (l_ones >= 127 && l_ones <= 129) else report_mismatch("midscale", "ones", 128, l_ones);
    assert (r_ones == l_ones) else report_mismatch("midscale", "right ones", l_ones, r_ones);

    // one voice is halved
    write_ctrl("gating", 32'h1d);
    wait_last_sample("gating", 64);
    count_ones(l_ones, r_ones);
    assert (l_ones >= 63 && l_ones <= 65) else report_mismatch("gating", "ones", 64, l_ones);
    write_ctrl("gating", 32'h15); // right speaker off
    count_ones(l_ones, r_ones);
    assert (r_ones == 0) else report_mismatch("gating", "right ones", 32'h0, r_ones);
    assert (l_ones > 0 && l_ones < 256) else abort_run("left speaker does not toggle");
    write_ctrl("gating", 32'h1c); // no voice
    wait_last_sample("gating", 0);
    count_ones(l_ones, r_ones);
    assert (l_ones == 0 && r_ones == 0)
      else report_mismatch("gating", "ones", 32'h0, 32'(l_ones + r_ones));

    // overflow with the player stopped
    write_ctrl("overflow", 32'h1f); // nonzero sample held when play stops
    wait_last_sample("overflow", 128);
    write_ctrl("overflow", 32'h0f);
    wait_samples(`AT_FIFO_DEPTH + 2);
    read_status("overflow", ovf, lvl, last);
    assert (ovf) else report_mismatch("overflow", "overflow", 32'h1, 32'(ovf));
    assert (lvl == `AT_FIFO_DEPTH) else report_mismatch("overflow", "level", `AT_FIFO_DEPTH, lvl);
    write_ctrl("overflow", 32'h8000_001f); // clear and play
    read_status("overflow", ovf, lvl, last);
    assert (!ovf) else report_mismatch("overflow", "overflow after clear", 32'h0, 32'(ovf));
    wait_samples(3);
    read_status("overflow", ovf, lvl, last);
    assert (!ovf) else report_mismatch("overflow", "overflow while playing", 32'h0, 32'(ovf));

    // moving tone, step between 1/64 and 1/16 of a turn
    random_word(incr_a);
    incr_a = (incr_a & 32'h0fff_ffff) | 32'h0400_0000;
    axil_write(`AT_ADDR_INCR0, incr_a, resp);
    write_ctrl("moving", 32'h1d);
    wait_samples(`AT_FIFO_DEPTH); // flush the midscale entries
    moved = 1'b0;
    first_last = -1;
    for (int i = 0; i < 8; i++) begin
      wait_samples(1);
      read_status("moving", ovf, lvl, last);
      assert (last <= 127) else report_mismatch("moving", "range", 32'h7f, last); // one voice halved
      if (first_last < 0) first_last = last;
      else if (last != first_last) moved = 1'b1;
      count_ones(l_ones, r_ones);
      assert (l_ones >= last - 2 && l_ones <= last + 2)
        else report_mismatch("moving", "ones", last, l_ones);
    end
    assert (moved) else abort_run("last_sample did not change across ticks");

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== audio_tone_top.f ====
+incdir+.
audio_tone_pkg.sv
audio_tone_regs.sv
sine_generator.sv
tone_source.sv
sample_fifo.sv
audio_player.sv
audio_tone_top.sv
tb_audio_tone.sv

// ==== Makefile ====
# Verilator build and run for the tone generator testbench

VERILATOR ?= verilator
TOP ?= tb_audio_tone
FILELIST ?= audio_tone_top.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
EXTRA_FLAGS ?=
FAIL_MSG ?= \*\*\* TEST FAILED \*\*\*

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) $(EXTRA_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
